// ==== common/upc_pkg.sv ====
package upc_pkg;

	localparam int DATA_W = 8;

	// Interrupt entry point and stack top
	localparam logic [DATA_W-1:0] IRQ_VECTOR = 8'h80;
	localparam logic [DATA_W-1:0] SP_RESET   = 8'hFF;

	// Upper instruction nibble, 00xx is the ALU group and 0100 to 0110 the exchange group
	typedef enum logic [3:0] {
		OPC_ALU  = 4'b0000,
		OPC_XCH  = 4'b0100,
		OPC_JAL  = 4'b0111,
		OPC_LD   = 4'b1000,
		OPC_ST   = 4'b1001,
		OPC_EI   = 4'b1010,
		OPC_MOV  = 4'b1011,
		OPC_PUSH = 4'b1100,
		OPC_POP  = 4'b1101,
		OPC_NOP  = 4'b1110
	} opcode_t;

	// MSB clear carries the opcode itself as the ALU function
	typedef enum logic [4:0] {
		DP_ADD       = 5'b00000,
		DP_SUB       = 5'b00001,
		DP_AND       = 5'b00010,
		DP_XOR       = 5'b00011,
		DP_MOV       = 5'b01011,
		DP_VECTOR    = 5'b10000,
		DP_STORE     = 5'b11000,
		DP_PUSH_ADDR = 5'b11001,
		DP_SP_DEC    = 5'b11010,
		DP_SP_INC    = 5'b11011,
		DP_FETCH     = 5'b11101,
		DP_FETCH_INT = 5'b11110,
		DP_PC_OUT    = 5'b11111
	} dp_op_t;

	// Register bank write source, RB_REG0 to RB_REG2 follow the exchange opcode low bits plus one
	typedef enum logic [2:0] {
		RB_LINK    = 3'b001,
		RB_MEM     = 3'b010,
		RB_POP     = 3'b011,
		RB_ACC_ALU = 3'b100,
		RB_REG0    = 3'b101,
		RB_REG1    = 3'b110,
		RB_REG2    = 3'b111
	} rb_sel_t;

endpackage

// ==== common/upc_ctrl_if.sv ====
`timescale 1ns/1ps

interface upc_ctrl_if;
	import upc_pkg::*;

	dp_op_t  op;
	logic    ir_we;
	logic    pc_we;
	rb_sel_t rb_sel_in;
	logic    rb_we;
	logic    sp_we;
	logic    mem_we;
	logic    ale;

	modport ctrl (
		output op, ir_we, pc_we, rb_sel_in, rb_we, sp_we, mem_we, ale
	);

	// Datapath and register bank only listen
	modport dp (
		input op, ir_we, pc_we, rb_sel_in, rb_we, sp_we, mem_we, ale
	);

endinterface

// ==== controller/up_controller.sv ====
`timescale 1ns/1ps

module up_controller (
	input  logic              clk,
	input  logic              nRst,
	input  logic              irq,
	input  upc_pkg::opcode_t  opcode,
	upc_ctrl_if.ctrl          ctl
);
	import upc_pkg::*;

	typedef enum logic [2:0] {
		S_FETCH_LATCH = 3'b001,
		S_FETCH_READ  = 3'b010,
		S_EXEC_1      = 3'b011,
		S_EXEC_2      = 3'b100,
		S_EXEC_3      = 3'b101
	} state_t;

	state_t state;
	logic   irq_en;
	logic   irq_last;
	logic   vec_q;
	logic   irq_take;
	logic   is_alu;
	logic   is_xch;
	logic   long_op;
	logic   mem_op;

	// Level is sampled once per fetch, so an edge during execute is still caught
	assign irq_take = irq & ~irq_last & irq_en;

	assign is_alu  = (opcode & 4'b1100) == OPC_ALU;
	assign is_xch  = ((opcode & 4'b1100) == OPC_XCH) && (opcode != OPC_JAL);
	assign long_op = is_xch || (opcode inside {OPC_JAL, OPC_LD, OPC_ST, OPC_PUSH, OPC_POP});
	assign mem_op  = opcode inside {OPC_LD, OPC_ST};

	always_comb begin
		ctl.op        = dp_op_t'({1'b0, opcode});
		ctl.ir_we     = 1'b0;
		ctl.pc_we     = 1'b0;
		ctl.rb_sel_in = RB_ACC_ALU;
		ctl.rb_we     = 1'b0;
		ctl.sp_we     = 1'b0;
		ctl.mem_we    = 1'b0;
		ctl.ale       = 1'b0;
		case (state)
			S_FETCH_LATCH: begin
				if (irq_take) begin
					ctl.op    = DP_VECTOR;
					ctl.pc_we = 1'b1;
				end else begin
					ctl.op  = (vec_q && irq) ? DP_FETCH_INT : DP_FETCH;
					ctl.ale = 1'b1;
				end
			end
			S_FETCH_READ: begin
				ctl.op    = DP_PC_OUT;
				ctl.ir_we = 1'b1;
				ctl.pc_we = 1'b1;
			end
			S_EXEC_1: begin
				if (is_alu) begin
					ctl.rb_we = 1'b1;
				end else if (is_xch) begin
					// Park the accumulator in the link register
					ctl.rb_sel_in = RB_LINK;
					ctl.rb_we     = 1'b1;
				end else begin
					case (opcode)
						OPC_JAL: begin
							ctl.rb_sel_in = RB_LINK;
							ctl.rb_we     = 1'b1;
						end
						OPC_LD, OPC_ST: ctl.ale = 1'b1;
						OPC_MOV: ctl.rb_we = 1'b1;
						OPC_PUSH: begin
							ctl.op  = DP_PUSH_ADDR;
							ctl.ale = 1'b1;
						end
						// SP points at the next free slot
						OPC_POP: begin
							ctl.op    = DP_SP_INC;
							ctl.sp_we = 1'b1;
						end
						default: ;
					endcase
				end
			end
			S_EXEC_2: begin
				if (is_xch) begin
					ctl.rb_sel_in = rb_sel_t'({1'b1, opcode[1:0] + 2'd1});
					ctl.rb_we     = 1'b1;
				end else begin
					case (opcode)
						OPC_JAL: ctl.pc_we = 1'b1;
						OPC_LD: begin
							ctl.rb_sel_in = RB_MEM;
							ctl.rb_we     = 1'b1;
						end
						OPC_ST, OPC_PUSH: begin
							ctl.op     = DP_STORE;
							ctl.mem_we = 1'b1;
						end
						OPC_POP: begin
							ctl.op  = DP_PUSH_ADDR;
							ctl.ale = 1'b1;
						end
						default: ;
					endcase
				end
			end
			S_EXEC_3: begin
				// Exchange is already done, its third cycle only keeps the timing
				case (opcode)
					OPC_JAL: begin
						ctl.rb_sel_in = RB_LINK;
						ctl.rb_we     = 1'b1;
					end
					OPC_PUSH: begin
						ctl.op    = DP_SP_DEC;
						ctl.sp_we = 1'b1;
					end
					OPC_POP: begin
						ctl.rb_sel_in = RB_POP;
						ctl.rb_we     = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state    <= S_FETCH_LATCH;
			irq_en   <= 1'b0;
			irq_last <= 1'b0;
			vec_q    <= 1'b0;
		end else begin
			case (state)
				S_FETCH_LATCH: begin
					irq_last <= irq;
					vec_q    <= irq_take;
					if (!irq_take)
						state <= S_FETCH_READ;
				end
				S_FETCH_READ: state <= S_EXEC_1;
				S_EXEC_1: begin
					if (opcode == OPC_EI)
						irq_en <= ~irq_en;
					state <= long_op ? S_EXEC_2 : S_FETCH_LATCH;
				end
				S_EXEC_2: state <= mem_op ? S_FETCH_LATCH : S_EXEC_3;
				default: state <= S_FETCH_LATCH;
			endcase
		end
	end

endmodule

// ==== datapath/up_datapath.sv ====
`timescale 1ns/1ps

module up_datapath (
	input  logic                        clk,
	input  logic                        nRst,
	upc_ctrl_if.dp                      ctl,
	output upc_pkg::opcode_t            opcode,
	output logic [upc_pkg::DATA_W-1:0]  pc,
	input  logic [upc_pkg::DATA_W-1:0]  acc,
	input  logic [upc_pkg::DATA_W-1:0]  r0,
	input  logic [upc_pkg::DATA_W-1:0]  link,
	output logic [upc_pkg::DATA_W-1:0]  alu_y,
	output logic [upc_pkg::DATA_W-1:0]  mem_data,
	input  logic [upc_pkg::DATA_W-1:0]  mem_rdata,
	output logic [upc_pkg::DATA_W-1:0]  mem_addr,
	output logic [upc_pkg::DATA_W-1:0]  mem_wdata,
	output logic                        mem_we
);
	import upc_pkg::*;

	logic [DATA_W-1:0] pc_q;
	logic [DATA_W-1:0] sp_q;
	logic [DATA_W-1:0] ir_q;
	logic [DATA_W-1:0] addr_q;
	logic [DATA_W-1:0] pc_d;
	logic [DATA_W-1:0] sp_d;
	logic [DATA_W-1:0] addr_d;
	logic [DATA_W-1:0] offset;

	assign opcode = opcode_t'(ir_q[7:4]);
	assign pc     = pc_q;

	// Load and store address is r0 plus the low instruction nibble
	assign offset = {{(DATA_W-4){1'b0}}, ir_q[3:0]};

	always_comb begin
		case (ctl.op)
			DP_ADD:  alu_y = acc + r0;
			DP_SUB:  alu_y = acc - r0;
			DP_AND:  alu_y = acc & r0;
			DP_XOR:  alu_y = acc ^ r0;
			DP_MOV:  alu_y = r0;
			default: alu_y = acc;
		endcase
	end

	always_comb begin
		case (ctl.op)
			DP_FETCH:     addr_d = pc_q;
			DP_FETCH_INT: addr_d = pc_q | IRQ_VECTOR;
			DP_PUSH_ADDR: addr_d = sp_q;
			default:      addr_d = r0 + offset;
		endcase
	end

	// Anything other than vector or increment is the jump target in link
	always_comb begin
		case (ctl.op)
			DP_VECTOR: pc_d = IRQ_VECTOR;
			DP_PC_OUT: pc_d = pc_q + 1'b1;
			default:   pc_d = link;
		endcase
	end

	always_comb begin
		case (ctl.op)
			DP_SP_INC: sp_d = sp_q + 1'b1;
			DP_SP_DEC: sp_d = sp_q - 1'b1;
			default:   sp_d = sp_q;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc_q   <= '0;
			sp_q   <= SP_RESET;
			ir_q   <= '0;
			addr_q <= '0;
		end else begin
			if (ctl.pc_we)
				pc_q <= pc_d;
			if (ctl.sp_we)
				sp_q <= sp_d;
			if (ctl.ir_we)
				ir_q <= mem_rdata;
			if (ctl.ale)
				addr_q <= addr_d;
		end
	end

	assign mem_addr  = addr_q;
	assign mem_wdata = (ctl.op == DP_STORE) ? acc : '0;
	assign mem_we    = ctl.mem_we;
	assign mem_data  = mem_rdata;

endmodule

// ==== datapath/up_reg_bank.sv ====
`timescale 1ns/1ps

module up_reg_bank (
	input  logic                        clk,
	input  logic                        nRst,
	upc_ctrl_if.dp                      ctl,
	input  logic [upc_pkg::DATA_W-1:0]  alu_y,
	input  logic [upc_pkg::DATA_W-1:0]  mem_data,
	input  logic [upc_pkg::DATA_W-1:0]  pc,
	output logic [upc_pkg::DATA_W-1:0]  acc,
	output logic [upc_pkg::DATA_W-1:0]  r0,
	output logic [upc_pkg::DATA_W-1:0]  link
);
	import upc_pkg::*;

	logic [DATA_W-1:0] regs [3];
	logic [1:0]        idx;

	// RB_REG0 sits at low bits 01
	assign idx = ctl.rb_sel_in[1:0] - 2'd1;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			acc     <= '0;
			link    <= '0;
			regs[0] <= '0;
			regs[1] <= '0;
			regs[2] <= '0;
		end else if (ctl.rb_we) begin
			case (ctl.rb_sel_in)
				RB_ACC_ALU: acc <= alu_y;
				RB_MEM, RB_POP: acc <= mem_data;
				// acc goes to link, acc takes the PC
				RB_LINK: begin
					link <= acc;
					acc  <= pc;
				end
				RB_REG0, RB_REG1, RB_REG2: begin
					acc       <= regs[idx];
					regs[idx] <= link;
				end
				default: ;
			endcase
		end
	end

	assign r0 = regs[0];

endmodule

// ==== source/up_core.sv ====
`timescale 1ns/1ps

module up_core (
	input  logic                        clk,
	input  logic                        nRst,
	input  logic                        irq,
	input  logic [upc_pkg::DATA_W-1:0]  mem_rdata,
	output logic [upc_pkg::DATA_W-1:0]  mem_addr,
	output logic [upc_pkg::DATA_W-1:0]  mem_wdata,
	output logic                        mem_we
);
	import upc_pkg::*;

	opcode_t           opcode;
	logic [DATA_W-1:0] pc;
	logic [DATA_W-1:0] acc;
	logic [DATA_W-1:0] r0;
	logic [DATA_W-1:0] link;
	logic [DATA_W-1:0] alu_y;
	logic [DATA_W-1:0] mem_data;

	upc_ctrl_if i_ctl ();

	up_controller i_controller (
		.clk    (clk),
		.nRst   (nRst),
		.irq    (irq),
		.opcode (opcode),
		.ctl    (i_ctl.ctrl)
	);

	up_datapath i_datapath (
		.clk       (clk),
		.nRst      (nRst),
		.ctl       (i_ctl.dp),
		.opcode    (opcode),
		.pc        (pc),
		.acc       (acc),
		.r0        (r0),
		.link      (link),
		.alu_y     (alu_y),
		.mem_data  (mem_data),
		.mem_rdata (mem_rdata),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_we    (mem_we)
	);

	up_reg_bank i_reg_bank (
		.clk      (clk),
		.nRst     (nRst),
		.ctl      (i_ctl.dp),
		.alu_y    (alu_y),
		.mem_data (mem_data),
		.pc       (pc),
		.acc      (acc),
		.r0       (r0),
		.link     (link)
	);

endmodule

// ==== sim/up_core_checker.sv ====
`timescale 1ns/1ps

module up_core_checker (
	input  logic                        clk,
	input  logic                        nRst,
	input  logic [upc_pkg::DATA_W-1:0]  mem_addr,
	input  logic [upc_pkg::DATA_W-1:0]  mem_wdata,
	input  logic                        mem_we,
	output int                          write_count,
	output int                          error_count
);

	logic [15:0] trace [0:511];
	logic [15:0] expected;
	int          expected_total;
	int          errs;

	// Expected writes are address and data pairs from word 0x110 on
	initial begin
		write_count = 0;
		error_count = 0;
		expected_total = 0;
		$readmemh("sim/up_core_trace.txt", trace);
		for (int t = 0; t < int'(trace['h108]); t++)
			expected_total += trace['h109 + t];
	end

	always @(posedge clk) begin
		if (nRst && mem_we) begin
			errs = 0;
			if (write_count >= expected_total) begin
				$display("Unexpected memory write at %0t to address %h", $time, mem_addr);
				errs = 1;
			end else begin
				expected = trace['h110 + write_count];
				if (mem_addr !== expected[15:8]) begin
					$display("FAILED at %0t: mem_addr expected %h, got %h",
						$time, expected[15:8], mem_addr);
					errs++;
				end
				if (mem_wdata !== expected[7:0]) begin
					$display("FAILED at %0t: mem_wdata expected %h, got %h",
						$time, expected[7:0], mem_wdata);
					errs++;
				end
			end
			write_count <= write_count + 1;
			error_count <= error_count + errs;
		end
	end

endmodule

// ==== sim/up_core_tb.sv ====
`timescale 1ns/1ps

module up_core_tb;

	localparam int TEST_TIMEOUT  = 1000;
	localparam int SETTLE_CYCLES = 200;

	logic        clk;
	logic        nRst;
	logic        irq;
	logic [7:0]  mem_rdata;
	logic [7:0]  mem_addr;
	logic [7:0]  mem_wdata;
	logic        mem_we;
	logic [7:0]  mem [0:255];
	logic [15:0] trace [0:511];
	int          cycle;
	int          last_write_cycle;
	int          write_count;
	int          error_count;
	int          target;
	int          waited;
	int          err_before;
	int          passed_tests;
	int          failed_tests;

	up_core i_dut (
		.clk       (clk),
		.nRst      (nRst),
		.irq       (irq),
		.mem_rdata (mem_rdata),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_we    (mem_we)
	);

	up_core_checker i_checker (
		.clk         (clk),
		.nRst        (nRst),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_we      (mem_we),
		.write_count (write_count),
		.error_count (error_count)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Memory answers in the same cycle
	assign mem_rdata = mem[mem_addr];

	// Memory writes and the irq schedule, counted in cycles after reset
	always @(posedge clk) begin
		if (mem_we) begin
			mem[mem_addr] <= mem_wdata;
			last_write_cycle <= cycle;
		end
		if (nRst) begin
			cycle <= cycle + 1;
			if (cycle == trace['h100])
				irq <= 1'b1;
			if (cycle == trace['h101])
				irq <= 1'b0;
			if (cycle == trace['h102])
				irq <= 1'b1;
		end
	end

	initial begin
		nRst = 1'b0;
		irq = 1'b0;
		cycle = 0;
		last_write_cycle = 0;
		target = 0;
		passed_tests = 0;
		failed_tests = 0;
		for (int i = 0; i < 256; i++)
			trace[i] = {8'h00, i[7:0] ^ 8'h5A};
		$readmemh("sim/up_core_trace.txt", trace);
		for (int i = 0; i < 256; i++)
			mem[i] = trace[i][7:0];

		repeat (5) @(posedge clk);
		nRst <= 1'b1;

		for (int t = 0; t < int'(trace['h108]); t++) begin
			target += trace['h109 + t];
			err_before = error_count;
			waited = 0;
			while (write_count < target && waited < TEST_TIMEOUT) begin
				@(posedge clk);
				waited++;
			end
			if (write_count < target) begin
				$display("Test %0d: memory writes did not arrive within %0d cycles",
					t + 1, TEST_TIMEOUT);
				failed_tests++;
			end else if (error_count != err_before) begin
				$display("Test %0d: failed", t + 1);
				failed_tests++;
			end else begin
				$display("Test %0d: passed", t + 1);
				passed_tests++;
			end
		end

		// The handler marker is the last expected write, a held irq level must not trigger it
		if (last_write_cycle <= int'(trace['h102])) begin
			$display("Interrupt marker store appeared before the last irq rising edge");
			failed_tests++;
		end

		// Nothing more may be written, the core only spins now
		err_before = error_count;
		waited = 0;
		while (waited < SETTLE_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		if (error_count != err_before) begin
			$display("Memory was written after the last expected write");
			failed_tests++;
		end

		$display("Tests passed: %0d, tests failed: %0d, write mismatches: %0d",
			passed_tests, failed_tests, error_count);
		if (failed_tests == 0 && passed_tests > 0 && error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== sim/up_core_trace.txt ====
// Words 000-0FF program image, 100-102 irq rise, fall and rise cycle
// Word 108 test count, 109 on writes per test, 110 on expected writes as addr then data
@000 008F 0070
@002 00A3
@00F 0020
@020 0082 0040 0080 0000 0091 0010 0092 0010 0093 0020 0094 0030 0095 00B0 0096
@02F 008E 0050 008F 0060 008D 0050 009A 0060 009B 0050 009C 0040 0000 0040 0090
@03E 0081 0092 00C0 0083 00C0 00D0 0094 00D0 0095
@047 0086 0070 0097 0098
@050 009E 00A0 008B 0070
@080 008F 009C 008D 0070
@0A3 005C
@0B0 0033 0011 0022
@0D7 006B
@0D9 00E4
@0DC 0050
@0E1 0053
@0E3 0083
@0E5 00A5
@100 000A 0190 01F4
@108 0005 0006 0004 0005 0001 0001
@110 A4FF A55C A6B9 A7A1 A802 A9A3
@116 AD11 AE22 AF33 D633
@11A D86B FF6B FEE4 DAE4 DB6B
@11F E450
@120 E2A5

// ==== up_core.f ====
common/upc_pkg.sv
common/upc_ctrl_if.sv
controller/up_controller.sv
datapath/up_datapath.sv
datapath/up_reg_bank.sv
source/up_core.sv
sim/up_core_checker.sv
sim/up_core_tb.sv
